/* common/bridge_consts.svh */
`ifndef BRIDGE_CONSTS_SVH
`define BRIDGE_CONSTS_SVH

// ----------------------------------------------------------------------
// AXI slave side
// ----------------------------------------------------------------------
`define AXI_ADDR_W   32
`define AXI_DATA_W   64
`define AXI_ID_W     4
`define AXI_STRB_W   8

// ----------------------------------------------------------------------
// APB master side
// ----------------------------------------------------------------------
`define APB_ADDR_W   12
`define APB_DATA_W   32

// Response codes on B and R
`define RESP_OKAY    2'b00
`define RESP_SLVERR  2'b10

// Size code of a beat that fills the whole 64-bit bus
`define SIZE_FULL    3'd3

`endif

/* common/axi_chan_pkg.sv */
`include "bridge_consts.svh"

package axi_chan_pkg;

    // ------------------------------------------------------------------
    // Field types
    // ------------------------------------------------------------------
    typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [`AXI_DATA_W-1:0] axi_data_t;
    typedef logic [`AXI_STRB_W-1:0] axi_strb_t;
    typedef logic [`AXI_ID_W-1:0]   axi_id_t;
    typedef logic [1:0]             axi_resp_t;
    typedef logic [2:0]             axi_size_t;

    // ------------------------------------------------------------------
    // Channel payloads
    // ------------------------------------------------------------------

    // AR and AW, single beats only
    typedef struct packed {
        axi_id_t   id;
        axi_addr_t addr;
        axi_size_t size;
    } axi_ax_t;

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;  // One bit per byte lane
    } axi_w_t;

    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        axi_resp_t resp;
    } axi_r_t;

    typedef struct packed {
        axi_id_t   id;
        axi_resp_t resp;
    } axi_b_t;

endpackage

/* common/apb_xfer_pkg.sv */
`include "bridge_consts.svh"

package apb_xfer_pkg;

    typedef logic [`APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [`APB_DATA_W-1:0] apb_data_t;

    // ------------------------------------------------------------------
    // Engine to arbiter handshake payloads
    // ------------------------------------------------------------------

    // One 32-bit APB transfer as asked for by an engine
    typedef struct packed {
        apb_addr_t addr;
        logic      write;
        apb_data_t wdata;  // Ignored on reads
    } apb_req_t;

    // Result of the transfer, valid with the done pulse
    typedef struct packed {
        apb_data_t rdata;
        logic      err;    // PSLVERR of the access phase
    } apb_rsp_t;

    // APB phase sequencer
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } arb_state_t;

endpackage

/* rtl/apb_arbiter.sv */
`timescale 1ns/1ns

module apb_arbiter (
    input  logic                    ACLK,
    input  logic                    ARESETn,

    // Read engine
    input  logic                    rd_req_i,
    input  apb_xfer_pkg::apb_req_t  rd_xfer_i,
    output logic                    rd_done_o,

    // Write engine
    input  logic                    wr_req_i,
    input  apb_xfer_pkg::apb_req_t  wr_xfer_i,
    output logic                    wr_done_o,

    output apb_xfer_pkg::apb_rsp_t  rsp_o,

    // APB3 master
    output logic                    psel_o,
    output logic                    penable_o,
    output logic                    pwrite_o,
    output apb_xfer_pkg::apb_addr_t paddr_o,
    output apb_xfer_pkg::apb_data_t pwdata_o,
    input  apb_xfer_pkg::apb_data_t prdata_i,
    input  logic                    pready_i,
    input  logic                    pslverr_i
);
    import apb_xfer_pkg::*;

    arb_state_t state_q;
    logic       grant_wr_q;  // Owner of the bus, 1 for the write engine
    apb_req_t   sel_xfer;
    logic       xfer_end;

    // Engines hold their request until done, so the bus stays stable
    assign sel_xfer = grant_wr_q ? wr_xfer_i : rd_xfer_i;

    // ------------------------------------------------------------------
    // APB outputs
    // ------------------------------------------------------------------
    assign psel_o    = (state_q != IDLE);
    assign penable_o = (state_q == ACCESS);
    assign pwrite_o  = sel_xfer.write;
    assign paddr_o   = sel_xfer.addr;
    assign pwdata_o  = sel_xfer.wdata;

    assign xfer_end  = (state_q == ACCESS) && pready_i;
    assign rd_done_o = xfer_end && !grant_wr_q;
    assign wr_done_o = xfer_end && grant_wr_q;

    always_comb begin
        rsp_o.rdata = prdata_i;
        rsp_o.err   = pslverr_i;
    end

    // ------------------------------------------------------------------
    // Phase FSM
    // ------------------------------------------------------------------
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q    <= IDLE;
            grant_wr_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (rd_req_i) begin          // Reads have priority
                        state_q    <= SETUP;
                        grant_wr_q <= 1'b0;
                    end else if (wr_req_i) begin
                        state_q    <= SETUP;
                        grant_wr_q <= 1'b1;
                    end
                end
                SETUP:   state_q <= ACCESS;
                ACCESS: begin
                    if (pready_i)
                        state_q <= IDLE;         // Grant is released after every word
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

/* rd_engine/axi_rd_engine.sv */
`timescale 1ns/1ns
`include "bridge_consts.svh"

module axi_rd_engine (
    input  logic                   ACLK,
    input  logic                   ARESETn,

    input  axi_chan_pkg::axi_ax_t  ar_i,
    input  logic                   ar_valid_i,
    output logic                   ar_ready_o,

    output axi_chan_pkg::axi_r_t   r_o,
    output logic                   r_valid_o,
    input  logic                   r_ready_i,

    output logic                   rd_req_o,
    output apb_xfer_pkg::apb_req_t rd_xfer_o,
    input  logic                   rd_done_i,
    input  apb_xfer_pkg::apb_rsp_t rd_rsp_i
);
    import axi_chan_pkg::*;
    import apb_xfer_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        RETURN
    } rd_state_t;

    rd_state_t  state_q;
    logic [1:0] need_q;     // Words still to fetch, bit 0 is the low word
    logic [1:0] need_left;  // need_q once the current word is done
    logic       word_sel;   // Word of the request on the bus
    logic       ar_hs;

    axi_id_t    id_q;
    apb_addr_t  addr_q;
    axi_data_t  rdata_q;
    logic       err_q;

    assign ar_ready_o = (state_q == IDLE);
    assign ar_hs      = ar_valid_i && ar_ready_o;
    assign word_sel   = ~need_q[0];  // Low word goes first

    always_comb begin
        need_left           = need_q;
        need_left[word_sel] = 1'b0;
    end

    // ------------------------------------------------------------------
    // Request to the arbiter and R channel
    // ------------------------------------------------------------------
    always_comb begin
        rd_req_o        = (state_q == FETCH);
        rd_xfer_o.addr  = {addr_q[`APB_ADDR_W-1:3], word_sel, 2'b00};
        rd_xfer_o.write = 1'b0;
        rd_xfer_o.wdata = '0;
    end

    always_comb begin
        r_valid_o = (state_q == RETURN);
        r_o.id    = id_q;
        r_o.data  = rdata_q;
        r_o.resp  = err_q ? `RESP_SLVERR : `RESP_OKAY;
    end

    // ------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q <= IDLE;
            need_q  <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (ar_hs) begin
                        state_q <= FETCH;
                        if (ar_i.size == `SIZE_FULL)
                            need_q <= 2'b11;
                        else
                            need_q <= ar_i.addr[2] ? 2'b10 : 2'b01;  // Narrow beat
                    end
                end
                FETCH: begin
                    if (rd_done_i) begin
                        need_q <= need_left;
                        if (need_left == 2'b00)
                            state_q <= RETURN;
                    end
                end
                RETURN: begin
                    if (r_ready_i)
                        state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Beat context and read data assembly
    always_ff @(posedge ACLK) begin
        if (ar_hs) begin
            id_q    <= ar_i.id;
            addr_q  <= ar_i.addr[`APB_ADDR_W-1:0];
            rdata_q <= '0;  // Words not fetched read as zero
            err_q   <= 1'b0;
        end else if (rd_done_i) begin
            if (word_sel)
                rdata_q[`AXI_DATA_W-1:`APB_DATA_W] <= rd_rsp_i.rdata;
            else
                rdata_q[`APB_DATA_W-1:0] <= rd_rsp_i.rdata;
            err_q <= err_q | rd_rsp_i.err;
        end
    end

endmodule

/* wr_engine/axi_wr_engine.sv */
`timescale 1ns/1ns
`include "bridge_consts.svh"

module axi_wr_engine (
    input  logic                   ACLK,
    input  logic                   ARESETn,

    input  axi_chan_pkg::axi_ax_t  aw_i,
    input  logic                   aw_valid_i,
    output logic                   aw_ready_o,
    input  axi_chan_pkg::axi_w_t   w_i,
    input  logic                   w_valid_i,
    output logic                   w_ready_o,

    output axi_chan_pkg::axi_b_t   b_o,
    output logic                   b_valid_o,
    input  logic                   b_ready_i,

    output logic                   wr_req_o,
    output apb_xfer_pkg::apb_req_t wr_xfer_o,
    input  logic                   wr_done_i,
    input  apb_xfer_pkg::apb_rsp_t wr_rsp_i
);
    import axi_chan_pkg::*;
    import apb_xfer_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        STORE,
        RESPOND
    } wr_state_t;

    wr_state_t  state_q;
    logic [1:0] need_q;     // Words still to write, bit 0 is the low word
    logic [1:0] need_left;
    logic [1:0] size_sel;   // Words covered by the beat size
    logic [1:0] strb_nz;    // Words with at least one strobe set
    logic [1:0] need_new;
    logic       word_sel;
    logic       wr_hs;
    apb_data_t  wdata_half;

    axi_id_t    id_q;
    apb_addr_t  addr_q;
    axi_data_t  wdata_q;
    logic       err_q;

    // AW and W are only taken together
    assign wr_hs      = (state_q == IDLE) && aw_valid_i && w_valid_i;
    assign aw_ready_o = wr_hs;
    assign w_ready_o  = wr_hs;

    always_comb begin
        if (aw_i.size == `SIZE_FULL)
            size_sel = 2'b11;
        else
            size_sel = aw_i.addr[2] ? 2'b10 : 2'b01;
        strb_nz  = {|w_i.strb[`AXI_STRB_W-1:`AXI_STRB_W/2], |w_i.strb[`AXI_STRB_W/2-1:0]};
        need_new = size_sel & strb_nz;
    end

    assign word_sel = ~need_q[0];

    always_comb begin
        need_left           = need_q;
        need_left[word_sel] = 1'b0;
    end

    // ------------------------------------------------------------------
    // Request to the arbiter and B channel
    // ------------------------------------------------------------------

    // No byte strobes on APB, the whole word is written
    assign wdata_half = word_sel ? wdata_q[`AXI_DATA_W-1:`APB_DATA_W]
                                 : wdata_q[`APB_DATA_W-1:0];

    always_comb begin
        wr_req_o        = (state_q == STORE);
        wr_xfer_o.addr  = {addr_q[`APB_ADDR_W-1:3], word_sel, 2'b00};
        wr_xfer_o.write = 1'b1;
        wr_xfer_o.wdata = wdata_half;
    end

    always_comb begin
        b_valid_o = (state_q == RESPOND);
        b_o.id    = id_q;
        b_o.resp  = err_q ? `RESP_SLVERR : `RESP_OKAY;
    end

    // ------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q <= IDLE;
            need_q  <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (wr_hs) begin
                        need_q <= need_new;
                        // Nothing to write goes straight to the response
                        state_q <= (need_new == 2'b00) ? RESPOND : STORE;
                    end
                end
                STORE: begin
                    if (wr_done_i) begin
                        need_q <= need_left;
                        if (need_left == 2'b00)
                            state_q <= RESPOND;
                    end
                end
                RESPOND: begin
                    if (b_ready_i)
                        state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (wr_hs) begin
            id_q    <= aw_i.id;
            addr_q  <= aw_i.addr[`APB_ADDR_W-1:0];
            wdata_q <= w_i.data;
            err_q   <= 1'b0;
        end else if (wr_done_i) begin
            err_q <= err_q | wr_rsp_i.err;  // Any failing word fails the beat
        end
    end

endmodule

/* rtl/axi2apb_bridge.sv */
`timescale 1ns/1ns

module axi2apb_bridge (
    input  logic                   ACLK,
    input  logic                   ARESETn,

    // AXI read address
    input  axi_chan_pkg::axi_ax_t  ar_i,
    input  logic                   ar_valid_i,
    output logic                   ar_ready_o,

    // AXI write address and data
    input  axi_chan_pkg::axi_ax_t  aw_i,
    input  logic                   aw_valid_i,
    output logic                   aw_ready_o,
    input  axi_chan_pkg::axi_w_t   w_i,
    input  logic                   w_valid_i,
    output logic                   w_ready_o,

    // AXI responses
    output axi_chan_pkg::axi_r_t   r_o,
    output logic                   r_valid_o,
    input  logic                   r_ready_i,
    output axi_chan_pkg::axi_b_t   b_o,
    output logic                   b_valid_o,
    input  logic                   b_ready_i,

    // APB3 master
    output logic                   psel_o,
    output logic                   penable_o,
    output logic                   pwrite_o,
    output apb_xfer_pkg::apb_addr_t paddr_o,
    output apb_xfer_pkg::apb_data_t pwdata_o,
    input  apb_xfer_pkg::apb_data_t prdata_i,
    input  logic                   pready_i,
    input  logic                   pslverr_i
);
    import apb_xfer_pkg::*;

    logic     rd_req;
    apb_req_t rd_xfer;
    logic     rd_done;
    logic     wr_req;
    apb_req_t wr_xfer;
    logic     wr_done;
    apb_rsp_t apb_rsp;  // Shared, qualified by rd_done or wr_done

    axi_rd_engine u_rd_engine (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .ar_i       (ar_i),
        .ar_valid_i (ar_valid_i),
        .ar_ready_o (ar_ready_o),
        .r_o        (r_o),
        .r_valid_o  (r_valid_o),
        .r_ready_i  (r_ready_i),
        .rd_req_o   (rd_req),
        .rd_xfer_o  (rd_xfer),
        .rd_done_i  (rd_done),
        .rd_rsp_i   (apb_rsp)
    );

    axi_wr_engine u_wr_engine (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .aw_i       (aw_i),
        .aw_valid_i (aw_valid_i),
        .aw_ready_o (aw_ready_o),
        .w_i        (w_i),
        .w_valid_i  (w_valid_i),
        .w_ready_o  (w_ready_o),
        .b_o        (b_o),
        .b_valid_o  (b_valid_o),
        .b_ready_i  (b_ready_i),
        .wr_req_o   (wr_req),
        .wr_xfer_o  (wr_xfer),
        .wr_done_i  (wr_done),
        .wr_rsp_i   (apb_rsp)
    );

    apb_arbiter u_apb_arbiter (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .rd_req_i   (rd_req),
        .rd_xfer_i  (rd_xfer),
        .rd_done_o  (rd_done),
        .wr_req_i   (wr_req),
        .wr_xfer_i  (wr_xfer),
        .wr_done_o  (wr_done),
        .rsp_o      (apb_rsp),
        .psel_o     (psel_o),
        .penable_o  (penable_o),
        .pwrite_o   (pwrite_o),
        .paddr_o    (paddr_o),
        .pwdata_o   (pwdata_o),
        .prdata_i   (prdata_i),
        .pready_i   (pready_i),
        .pslverr_i  (pslverr_i)
    );

endmodule

/* dv/apb_slave_model.sv */
`timescale 1ns/1ns

module apb_slave_model (
    input  logic                    ACLK,
    input  logic                    ARESETn,
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  apb_xfer_pkg::apb_addr_t paddr_i,
    input  apb_xfer_pkg::apb_data_t pwdata_i,
    output apb_xfer_pkg::apb_data_t prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o
);
    import apb_xfer_pkg::*;

    apb_data_t  mem [0:1023];
    logic [1:0] wait_q;      // Wait states left in the access phase
    logic [9:0] word_idx;
    logic       err_region;  // Upper half of the APB space fails

    assign word_idx   = paddr_i[11:2];
    assign err_region = paddr_i[11];

    // Every word starts with a value of its own
    initial begin
        for (int i = 0; i < 1024; i++)
            mem[10'(i)] = 32'h5a00_0000 ^ ({22'd0, 10'(i)} * 32'h0001_0101);
    end

    assign pready_o  = psel_i && penable_i && (wait_q == 2'd0);
    assign pslverr_o = pready_o && err_region;
    assign prdata_o  = (pready_o && !pwrite_i && !err_region) ? mem[word_idx] : '0;

    // ------------------------------------------------------------------
    // Wait states and memory
    // ------------------------------------------------------------------
    always @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            wait_q <= 2'd0;
        end else if (psel_i && !penable_i) begin
            wait_q <= 2'($urandom % 4);  // Picked in the setup phase
        end else if (penable_i && wait_q != 2'd0) begin
            wait_q <= wait_q - 2'd1;
        end
    end

    always @(posedge ACLK) begin
        if (pready_o && pwrite_i && !err_region)
            mem[word_idx] <= pwdata_i;
    end

endmodule

/* dv/tb_axi2apb.sv */
`timescale 1ns/1ns
`include "bridge_consts.svh"

module tb_axi2apb;
    import axi_chan_pkg::*;
    import apb_xfer_pkg::*;

    // About 70 beats of at most ~50 cycles each with stalls, so 20000 leaves wide margin
    localparam int TIMEOUT_CYCLES = 20000;

    logic      ACLK;
    logic      ARESETn;
    axi_ax_t   ar;
    logic      ar_valid;
    logic      ar_ready;
    axi_ax_t   aw;
    logic      aw_valid;
    logic      aw_ready;
    axi_w_t    w;
    logic      w_valid;
    logic      w_ready;
    axi_r_t    r;
    logic      r_valid;
    logic      r_ready;
    axi_b_t    b;
    logic      b_valid;
    logic      b_ready;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;

    apb_data_t sb_mem [0:1023];  // Expected APB memory contents
    int        data_errs = 0;
    int        proto_errs = 0;
    int        cycle_cnt = 0;
    logic      rd_first = 1'b0;  // Next setup phase must be a read
    logic      rd_pending = 1'b0;
    logic      wr_pending = 1'b0;
    logic      prev_psel = 1'b0;
    logic      prev_penable = 1'b0;
    logic      prev_pready = 1'b0;
    logic      prev_pwrite;
    apb_addr_t prev_paddr;
    apb_data_t prev_pwdata;
    logic      prev_r_stall = 1'b0;
    logic      prev_b_stall = 1'b0;
    axi_r_t    prev_r;
    axi_b_t    prev_b;

    axi2apb_bridge u_axi2apb_bridge (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .ar_i(ar), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready),
        .aw_i(aw), .aw_valid_i(aw_valid), .aw_ready_o(aw_ready),
        .w_i(w), .w_valid_i(w_valid), .w_ready_o(w_ready),
        .r_o(r), .r_valid_o(r_valid), .r_ready_i(r_ready),
        .b_o(b), .b_valid_o(b_valid), .b_ready_i(b_ready),
        .psel_o(psel), .penable_o(penable), .pwrite_o(pwrite), .paddr_o(paddr),
        .pwdata_o(pwdata), .prdata_i(prdata), .pready_i(pready), .pslverr_i(pslverr)
    );

    apb_slave_model u_apb_slave_model (
        .ACLK(ACLK), .ARESETn(ARESETn),
        .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
        .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
    );

    initial begin
        ACLK = 1'b0;
        forever #5 ACLK = ~ACLK;
    end

    // ------------------------------------------------------------------
    // Reference model of the bridge and the APB memory
    // ------------------------------------------------------------------
    function automatic apb_data_t fill_word(input logic [9:0] idx);
        return 32'h5a00_0000 ^ ({22'd0, idx} * 32'h0001_0101);
    endfunction

    // Full beats cover both words, narrow ones the word of address bit 2
    function automatic logic [1:0] word_mask(input axi_addr_t addr, input axi_size_t size);
        if (size == `SIZE_FULL)
            return 2'b11;
        return addr[2] ? 2'b10 : 2'b01;
    endfunction

    function automatic axi_resp_t model_write(input axi_addr_t addr, input axi_size_t size,
                                              input axi_data_t data, input axi_strb_t strb);
        logic [1:0] sel;
        logic       any;
        sel = word_mask(addr, size);
        any = 1'b0;
        for (int k = 0; k < 2; k++) begin
            if (sel[k] && strb[4*k +: 4] != 4'h0) begin
                any = 1'b1;
                if (!addr[11])
                    sb_mem[{addr[11:3], 1'(k)}] = data[32*k +: 32];
            end
        end
        return (any && addr[11]) ? `RESP_SLVERR : `RESP_OKAY;
    endfunction

    function automatic axi_data_t model_read(input axi_addr_t addr, input axi_size_t size);
        logic [1:0] sel;
        axi_data_t  exp;
        sel = word_mask(addr, size);
        exp = '0;
        for (int k = 0; k < 2; k++) begin
            if (sel[k] && !addr[11])
                exp[32*k +: 32] = sb_mem[{addr[11:3], 1'(k)}];
        end
        return exp;
    endfunction

    // ------------------------------------------------------------------
    // AXI transactions, inputs driven 1 ns after the rising edge
    // ------------------------------------------------------------------
    task automatic axi_write(input axi_id_t id, input axi_addr_t addr, input axi_size_t size,
                             input axi_data_t data, input axi_strb_t strb);
        axi_resp_t exp_resp;
        logic      done;
        exp_resp = model_write(addr, size, data, strb);
        @(posedge ACLK);
        #1;
        aw.id    = id;
        aw.addr  = addr;
        aw.size  = size;
        w.data   = data;
        w.strb   = strb;
        aw_valid = 1'b1;
        w_valid  = 1'b1;
        @(negedge ACLK);
        while (!aw_ready) @(negedge ACLK);
        @(posedge ACLK);
        #1;
        aw_valid = 1'b0;
        w_valid  = 1'b0;
        done     = 1'b0;
        while (!done) begin
            b_ready = ($urandom % 4) != 0;  // Stall about one cycle in four
            @(negedge ACLK);
            if (b_valid && b_ready) begin
                assert (b.id == id && b.resp == exp_resp) else begin
                    data_errs++;
                    $display("Mismatch at %0t: B id %0h resp %0d, expected id %0h resp %0d",
                             $time, b.id, b.resp, id, exp_resp);
                end
                done = 1'b1;
            end
            @(posedge ACLK);
            #1;
        end
        b_ready = 1'b0;
    endtask

    task automatic axi_read(input axi_id_t id, input axi_addr_t addr, input axi_size_t size);
        axi_data_t exp_data;
        axi_resp_t exp_resp;
        logic      done;
        exp_data = model_read(addr, size);
        exp_resp = addr[11] ? `RESP_SLVERR : `RESP_OKAY;
        @(posedge ACLK);
        #1;
        ar.id    = id;
        ar.addr  = addr;
        ar.size  = size;
        ar_valid = 1'b1;
        @(negedge ACLK);
        while (!ar_ready) @(negedge ACLK);
        @(posedge ACLK);
        #1;
        ar_valid = 1'b0;
        done     = 1'b0;
        while (!done) begin
            r_ready = ($urandom % 4) != 0;
            @(negedge ACLK);
            if (r_valid && r_ready) begin
                assert (r.id == id && r.data == exp_data && r.resp == exp_resp) else begin
                    data_errs++;
                    $display("Mismatch at %0t: R id %0h data %h resp %0d", $time,
                             r.id, r.data, r.resp);
                    $display("  expected id %0h data %h resp %0d", id, exp_data, exp_resp);
                end
                done = 1'b1;
            end
            @(posedge ACLK);
            #1;
        end
        r_ready = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // APB and AXI channel rules, sampled at the falling edge
    // ------------------------------------------------------------------
    always @(negedge ACLK) begin
        if (ARESETn) begin
            if (penable && !prev_penable)
                assert (psel && prev_psel) else begin
                    proto_errs++;
                    $display("Mismatch at %0t: penable rose without a setup phase", $time);
                end
            if (prev_psel && !(prev_penable && prev_pready))
                assert (psel && paddr == prev_paddr && pwrite == prev_pwrite &&
                        pwdata == prev_pwdata) else begin
                    proto_errs++;
                    $display("Mismatch at %0t: APB transfer changed before pready", $time);
                end
            if (rd_first && psel && !penable) begin
                assert (!pwrite) else begin
                    proto_errs++;
                    $display("Mismatch at %0t: write won over a read of the same cycle", $time);
                end
                rd_first = 1'b0;
            end
            if (prev_r_stall)
                assert (r_valid && r == prev_r) else begin
                    proto_errs++;
                    $display("Mismatch at %0t: R changed while stalled", $time);
                end
            if (prev_b_stall)
                assert (b_valid && b == prev_b) else begin
                    proto_errs++;
                    $display("Mismatch at %0t: B changed while stalled", $time);
                end
            assert (!(rd_pending && ar_ready) && !(wr_pending && (aw_ready || w_ready)) &&
                    aw_ready == w_ready) else begin
                proto_errs++;
                $display("Mismatch at %0t: address ready while a response is pending", $time);
            end
            if (ar_valid && ar_ready)
                rd_pending = 1'b1;
            if (r_valid && r_ready)
                rd_pending = 1'b0;
            if (aw_valid && aw_ready)
                wr_pending = 1'b1;
            if (b_valid && b_ready)
                wr_pending = 1'b0;
        end
        prev_psel    = psel;
        prev_penable = penable;
        prev_pready  = pready;
        prev_pwrite  = pwrite;
        prev_paddr   = paddr;
        prev_pwdata  = pwdata;
        prev_r_stall = r_valid && !r_ready;
        prev_b_stall = b_valid && !b_ready;
        prev_r       = r;
        prev_b       = b;
    end

    always @(posedge ACLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the bridge stopped responding", cycle_cnt);
            $display("Something failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------
    initial begin
        axi_addr_t addr;
        axi_size_t size;
        axi_strb_t strb;
        void'($urandom(32'h68cb08eb));
        ARESETn  = 1'b0;
        ar       = '0;
        ar_valid = 1'b0;
        aw       = '0;
        aw_valid = 1'b0;
        w        = '0;
        w_valid  = 1'b0;
        r_ready  = 1'b0;
        b_ready  = 1'b0;
        for (int i = 0; i < 1024; i++)
            sb_mem[10'(i)] = fill_word(10'(i));
        repeat (8) @(posedge ACLK);
        assert (!psel && !penable && !aw_ready && !w_ready && !r_valid && !b_valid) else begin
            proto_errs++;
            $display("Mismatch at %0t: outputs active in reset", $time);
        end
        #1 ARESETn = 1'b1;

        axi_write(4'h3, 32'h040, `SIZE_FULL, 64'h0123_4567_89ab_cdef, 8'hff);
        axi_read(4'h5, 32'h040, `SIZE_FULL);
        axi_read(4'h1, 32'h084, 3'd2);              // Upper word only
        axi_read(4'h2, 32'h080, 3'd2);
        axi_write(4'h6, 32'h044, 3'd2, 64'hdead_beef_0000_0000, 8'hf0);
        axi_read(4'h7, 32'h040, `SIZE_FULL);
        axi_write(4'h8, 32'h100, `SIZE_FULL, 64'h1111_2222_3333_4444, 8'hff);
        axi_write(4'h9, 32'h100, `SIZE_FULL, 64'h5555_6666_7777_8888, 8'h0f);
        axi_write(4'ha, 32'h100, `SIZE_FULL, 64'h9999_aaaa_bbbb_cccc, 8'h00);
        axi_read(4'hb, 32'h100, `SIZE_FULL);
        axi_write(4'hc, 32'h800, `SIZE_FULL, 64'hffff_0000_ffff_0000, 8'hff);  // Error region
        axi_read(4'hd, 32'h808, `SIZE_FULL);
        axi_read(4'he, 32'h804, 3'd2);

        // Read and write launched in the same cycle
        rd_first = 1'b1;
        fork
            axi_read(4'h4, 32'h040, `SIZE_FULL);
            axi_write(4'hf, 32'h180, `SIZE_FULL, 64'h0f0f_f0f0_1234_5678, 8'hff);
        join

        // Second write is offered while the first one waits for its response
        fork
            axi_write(4'h1, 32'h1c0, `SIZE_FULL, 64'h2468_ace0_1357_9bdf, 8'hff);
            begin
                wait (wr_pending);
                @(posedge ACLK);
                #2;
                axi_write(4'h2, 32'h1c8, `SIZE_FULL, 64'h7654_3210_fedc_ba98, 8'hff);
            end
        join
        axi_read(4'h3, 32'h1c0, `SIZE_FULL);
        axi_read(4'h6, 32'h1c8, `SIZE_FULL);

        for (int n = 0; n < 48; n++) begin
            size = 3'($urandom % 4);
            addr = {20'h0, ($urandom % 8) == 0, 4'b0100, 4'($urandom), 1'($urandom), 2'b00};
            if (size == `SIZE_FULL) begin
                addr[2] = 1'b0;
                strb    = 8'($urandom);
            end else begin
                strb = addr[2] ? {4'($urandom), 4'h0} : {4'h0, 4'($urandom)};
            end
            if ($urandom % 2 == 0)
                axi_write(4'(n), addr, size, {$urandom, $urandom}, strb);
            else
                axi_read(4'(n), addr, size);
        end

        repeat (4) @(posedge ACLK);
        $display("Checks done: %0d data errors, %0d protocol errors", data_errs, proto_errs);
        if (data_errs + proto_errs == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+common
common/axi_chan_pkg.sv
common/apb_xfer_pkg.sv
rtl/apb_arbiter.sv
rd_engine/axi_rd_engine.sv
wr_engine/axi_wr_engine.sv
rtl/axi2apb_bridge.sv
dv/apb_slave_model.sv
dv/tb_axi2apb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_axi2apb -Mdir obj_dir -f verilog.f

out=$(./obj_dir/Vtb_axi2apb)
echo "$out"

# Pass only if the testbench printed the pass message
echo "$out" | grep -qx "Everything OK"
